/* src/tl_pkg.sv */
//******************************
// lamp and walk codes, phase enum,
// axis and turn types, key-bit positions
//******************************
package tl_pkg;

	// vehicle lamp, bits ordered green, yellow, red with one bit lit
	typedef logic [2:0] lamp_t;

	localparam lamp_t LAMP_GREEN  = 3'b100;
	localparam lamp_t LAMP_YELLOW = 3'b010;
	localparam lamp_t LAMP_RED    = 3'b001;

	// crosswalk head, white walk sign, countdown or red hand
	typedef logic [2:0] walk_t;

	localparam walk_t WALK_ON    = 3'b100;
	localparam walk_t WALK_FLASH = 3'b010;
	localparam walk_t WALK_OFF   = 3'b001;

	// controller phases, straight and turn sequences share the same pacing
	typedef enum logic [3:0] {
		PH_IDLE,
		PH_CHECK,
		PH_NIGHT,
		PH_STR_WALK,
		PH_STR_FLASH,
		PH_STR_GREEN,
		PH_STR_YELLOW,
		PH_STR_CLEAR,
		PH_TURN_WALK,
		PH_TURN_FLASH,
		PH_TURN_YELLOW,
		PH_TURN_CLEAR
	} phase_t;

	typedef enum logic {
		AXIS_EW,
		AXIS_SN
	} axis_t;

	// protected turns in the order they rotate on heavy traffic
	typedef enum logic [1:0] {
		TURN_ES,
		TURN_WN,
		TURN_SW,
		TURN_NE
	} turn_t;

	localparam int KEY_W = 8;

	// two key bits per crosswalk, either one requests a walk
	localparam int KEY_EWS_A = 5;
	localparam int KEY_EWS_B = 6;
	localparam int KEY_EWN_A = 1;
	localparam int KEY_EWN_B = 2;
	localparam int KEY_SNE_A = 3;
	localparam int KEY_SNE_B = 4;
	localparam int KEY_SNW_A = 0;
	localparam int KEY_SNW_B = 7;

endpackage

/* src/phase_sequencer.sv */
//******************************
// phase FSM with axis alternation
// and heavy-traffic turn rotation
//******************************
`timescale 1ns/1ps

module phase_sequencer (
	input  logic           clk,
	input  logic           reset,
	input  logic           start,
	input  logic           daytime,
	input  logic           heavy_traffic,
	input  logic           walk_end,
	input  logic           green_end,
	input  logic           yellow_end,
	input  logic [1:0]     grant,
	output tl_pkg::phase_t phase,
	output tl_pkg::axis_t  axis,
	output tl_pkg::turn_t  turn,
	output logic           capture
);

	import tl_pkg::*;

	logic has_grant;

	// only whether any crosswalk was granted matters here, not which one
	assign has_grant = |grant;

	// the key is sampled as the controller commits to a normal cycle
	assign capture = (phase == PH_CHECK) && daytime && !heavy_traffic;

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= PH_IDLE;
			axis  <= AXIS_EW;
			turn  <= TURN_ES;
		end else begin
			case (phase)
				PH_IDLE: begin
					if (start) begin
						phase <= PH_CHECK;
					end
				end

				PH_CHECK: begin
					if (!daytime) begin
						phase <= PH_NIGHT;
					end else if (heavy_traffic) begin
						// every heavy cycle starts the rotation from ES
						phase <= PH_TURN_WALK;
						turn  <= TURN_ES;
					end else begin
						phase <= PH_STR_WALK;
					end
				end

				PH_NIGHT: begin
					if (daytime) begin
						phase <= PH_CHECK;
					end
				end

				PH_STR_WALK: begin
					// with no walk granted this phase is plain green and skips the flash
					if (has_grant) begin
						if (walk_end) begin
							phase <= PH_STR_FLASH;
						end
					end else if (green_end) begin
						phase <= PH_STR_YELLOW;
					end
				end

				PH_STR_FLASH,
				PH_STR_GREEN: begin
					if (green_end) begin
						phase <= PH_STR_YELLOW;
					end
				end

				PH_STR_YELLOW: begin
					if (yellow_end) begin
						phase <= PH_STR_CLEAR;
					end
				end

				PH_STR_CLEAR: begin
					// all red for one cycle, then the other axis gets its turn
					phase <= PH_CHECK;
					axis  <= (axis == AXIS_EW) ? AXIS_SN : AXIS_EW;
				end

				PH_TURN_WALK: begin
					if (walk_end) begin
						phase <= PH_TURN_FLASH;
					end
				end

				PH_TURN_FLASH: begin
					if (green_end) begin
						phase <= PH_TURN_YELLOW;
					end
				end

				PH_TURN_YELLOW: begin
					if (yellow_end) begin
						phase <= PH_TURN_CLEAR;
					end
				end

				PH_TURN_CLEAR: begin
					// the axis is left alone so the next normal cycle keeps the one due
					if (turn == TURN_NE) begin
						phase <= PH_CHECK;
						turn  <= TURN_ES;
					end else begin
						phase <= PH_TURN_WALK;
						turn  <= turn_t'(turn + 2'd1);
					end
				end

				default: begin
					phase <= PH_IDLE;
				end
			endcase
		end
	end

endmodule

/* src/walk_grant.sv */
//******************************
// pedestrian key decode and grant
// register for the coming axis
//******************************
`timescale 1ns/1ps

module walk_grant (
	input  logic                     clk,
	input  logic                     reset,
	input  logic [tl_pkg::KEY_W-1:0] pass_key,
	input  tl_pkg::axis_t            axis,
	input  logic                     capture,
	output logic [1:0]               grant
);

	import tl_pkg::*;

	logic near_req;
	logic far_req;

	// near side is EWS or SNE, far side is EWN or SNW
	always_comb begin
		if (axis == AXIS_EW) begin
			near_req = pass_key[KEY_EWS_A] | pass_key[KEY_EWS_B];
			far_req  = pass_key[KEY_EWN_A] | pass_key[KEY_EWN_B];
		end else begin
			near_req = pass_key[KEY_SNE_A] | pass_key[KEY_SNE_B];
			far_req  = pass_key[KEY_SNW_A] | pass_key[KEY_SNW_B];
		end
	end

	// held from capture until the next capture, so it covers the whole straight sequence
	always_ff @(posedge clk) begin
		if (reset) begin
			grant <= 2'b00;
		end else if (capture) begin
			grant <= {far_req, near_req};
		end
	end

endmodule

/* src/signal_head_decoder.sv */
//******************************
// lamp, walk and need decoding
// from phase, axis, turn and grant
//******************************
`timescale 1ns/1ps

module signal_head_decoder (
	input  tl_pkg::phase_t phase,
	input  tl_pkg::axis_t  axis,
	input  tl_pkg::turn_t  turn,
	input  logic [1:0]     grant,
	output logic           need_walk_end,
	output logic           need_green_end,
	output logic           need_yellow_end,
	output tl_pkg::lamp_t  ew_straight,
	output tl_pkg::lamp_t  sn_straight,
	output logic           es_turn,
	output logic           wn_turn,
	output logic           sw_turn,
	output logic           ne_turn,
	output tl_pkg::walk_t  ews_walk,
	output tl_pkg::walk_t  ewn_walk,
	output tl_pkg::walk_t  sne_walk,
	output tl_pkg::walk_t  snw_walk
);

	import tl_pkg::*;

	axis_t      turn_axis;
	logic [1:0] turn_sel;
	axis_t      head_axis;
	lamp_t      head_lamp;
	walk_t      head_walk;
	logic [1:0] walk_sel;
	logic       turn_on;

	// ES and WN run with the EW straight, SW and NE with the SN straight
	assign turn_axis = (turn == TURN_ES || turn == TURN_WN) ? AXIS_EW : AXIS_SN;

	// each turn has a fixed crosswalk, given as {far, near} like the grant
	assign turn_sel = (turn == TURN_ES || turn == TURN_NE) ? 2'b10 : 2'b01;

	always_comb begin
		head_axis       = axis;
		head_lamp       = LAMP_RED;
		head_walk       = WALK_OFF;
		walk_sel        = grant;
		turn_on         = 1'b0;
		need_walk_end   = 1'b0;
		need_green_end  = 1'b0;
		need_yellow_end = 1'b0;

		case (phase)
			PH_STR_WALK: begin
				head_lamp      = LAMP_GREEN;
				head_walk      = WALK_ON;
				need_walk_end  = |grant;
				need_green_end = ~|grant;
			end
			PH_STR_FLASH: begin
				head_lamp      = LAMP_GREEN;
				head_walk      = WALK_FLASH;
				need_green_end = 1'b1;
			end
			PH_STR_GREEN: begin
				head_lamp      = LAMP_GREEN;
				need_green_end = 1'b1;
			end
			PH_STR_YELLOW: begin
				head_lamp       = LAMP_YELLOW;
				head_walk       = WALK_FLASH;
				need_yellow_end = 1'b1;
			end
			PH_TURN_WALK: begin
				head_axis     = turn_axis;
				head_lamp     = LAMP_GREEN;
				head_walk     = WALK_ON;
				walk_sel      = turn_sel;
				turn_on       = 1'b1;
				need_walk_end = 1'b1;
			end
			PH_TURN_FLASH: begin
				head_axis      = turn_axis;
				head_lamp      = LAMP_GREEN;
				head_walk      = WALK_FLASH;
				walk_sel       = turn_sel;
				turn_on        = 1'b1;
				need_green_end = 1'b1;
			end
			PH_TURN_YELLOW: begin
				// turn arrow is already dark, the crosswalk keeps counting down
				head_axis       = turn_axis;
				head_lamp       = LAMP_YELLOW;
				head_walk       = WALK_FLASH;
				walk_sel        = turn_sel;
				need_yellow_end = 1'b1;
			end
			default: begin
				// idle, check, night and both clear phases show all red
				head_lamp = LAMP_RED;
			end
		endcase
	end

	// the axis not being served is always held red
	assign ew_straight = (head_axis == AXIS_EW) ? head_lamp : LAMP_RED;
	assign sn_straight = (head_axis == AXIS_SN) ? head_lamp : LAMP_RED;

	assign es_turn = turn_on && (turn == TURN_ES);
	assign wn_turn = turn_on && (turn == TURN_WN);
	assign sw_turn = turn_on && (turn == TURN_SW);
	assign ne_turn = turn_on && (turn == TURN_NE);

	assign ews_walk = (head_axis == AXIS_EW && walk_sel[0]) ? head_walk : WALK_OFF;
	assign ewn_walk = (head_axis == AXIS_EW && walk_sel[1]) ? head_walk : WALK_OFF;
	assign sne_walk = (head_axis == AXIS_SN && walk_sel[0]) ? head_walk : WALK_OFF;
	assign snw_walk = (head_axis == AXIS_SN && walk_sel[1]) ? head_walk : WALK_OFF;

endmodule

/* src/traffic_light_ctrl.sv */
//******************************
// top level of the intersection
// signal-light controller
//******************************
`timescale 1ns/1ps

module traffic_light_ctrl (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     start,
	input  logic                     daytime,
	input  logic                     heavy_traffic,
	input  logic [tl_pkg::KEY_W-1:0] pass_key,
	input  logic                     walk_end,
	input  logic                     green_end,
	input  logic                     yellow_end,
	output logic                     need_walk_end,
	output logic                     need_green_end,
	output logic                     need_yellow_end,
	output tl_pkg::lamp_t            ew_straight,
	output tl_pkg::lamp_t            sn_straight,
	output logic                     es_turn,
	output logic                     wn_turn,
	output logic                     sw_turn,
	output logic                     ne_turn,
	output tl_pkg::walk_t            ews_walk,
	output tl_pkg::walk_t            ewn_walk,
	output tl_pkg::walk_t            sne_walk,
	output tl_pkg::walk_t            snw_walk
);

	import tl_pkg::*;

	phase_t     phase;
	axis_t      axis;
	turn_t      turn;
	logic       capture;
	logic [1:0] grant;

	// sequencing, the grant it branches on, and lamp decoding are kept apart
	phase_sequencer phase_sequencer_inst (
		.clk           (clk),
		.reset         (reset),
		.start         (start),
		.daytime       (daytime),
		.heavy_traffic (heavy_traffic),
		.walk_end      (walk_end),
		.green_end     (green_end),
		.yellow_end    (yellow_end),
		.grant         (grant),
		.phase         (phase),
		.axis          (axis),
		.turn          (turn),
		.capture       (capture)
	);

	walk_grant walk_grant_inst (
		.clk      (clk),
		.reset    (reset),
		.pass_key (pass_key),
		.axis     (axis),
		.capture  (capture),
		.grant    (grant)
	);

	signal_head_decoder signal_head_decoder_inst (
		.phase           (phase),
		.axis            (axis),
		.turn            (turn),
		.grant           (grant),
		.need_walk_end   (need_walk_end),
		.need_green_end  (need_green_end),
		.need_yellow_end (need_yellow_end),
		.ew_straight     (ew_straight),
		.sn_straight     (sn_straight),
		.es_turn         (es_turn),
		.wn_turn         (wn_turn),
		.sw_turn         (sw_turn),
		.ne_turn         (ne_turn),
		.ews_walk        (ews_walk),
		.ewn_walk        (ewn_walk),
		.sne_walk        (sne_walk),
		.snw_walk        (snw_walk)
	);

endmodule

/* verification/tb_traffic_light_ctrl.sv */
//******************************
// testbench for the signal-light controller
// file-driven stimulus, output checks, watchdog
//******************************
`timescale 1ns/1ps

module tb_traffic_light_ctrl;

	import tl_pkg::*;

	localparam int NUM_LINES  = 58;
	localparam int FIELDS     = 13;
	localparam int CLK_PERIOD = 4;
	localparam int TIMEOUT_NS = NUM_LINES * CLK_PERIOD * 2;

	// field positions inside one line of the data file
	localparam int F_START = 0;
	localparam int F_DAY   = 1;
	localparam int F_HEAVY = 2;
	localparam int F_KEY   = 3;
	localparam int F_PULSE = 4;
	localparam int F_NEED  = 5;
	localparam int F_EW    = 6;
	localparam int F_SN    = 7;
	localparam int F_TURNS = 8;
	localparam int F_EWS   = 9;
	localparam int F_EWN   = 10;
	localparam int F_SNE   = 11;
	localparam int F_SNW   = 12;

	logic             clk;
	logic             reset;
	logic             start;
	logic             daytime;
	logic             heavy_traffic;
	logic [KEY_W-1:0] pass_key;
	logic             walk_end;
	logic             green_end;
	logic             yellow_end;
	logic             need_walk_end;
	logic             need_green_end;
	logic             need_yellow_end;
	lamp_t            ew_straight;
	lamp_t            sn_straight;
	logic             es_turn;
	logic             wn_turn;
	logic             sw_turn;
	logic             ne_turn;
	walk_t            ews_walk;
	walk_t            ewn_walk;
	walk_t            sne_walk;
	walk_t            snw_walk;

	logic [7:0] vec_mem [0:NUM_LINES*FIELDS-1];
	int         cur_step;

	traffic_light_ctrl traffic_light_ctrl_inst (
		.clk             (clk),
		.reset           (reset),
		.start           (start),
		.daytime         (daytime),
		.heavy_traffic   (heavy_traffic),
		.pass_key        (pass_key),
		.walk_end        (walk_end),
		.green_end       (green_end),
		.yellow_end      (yellow_end),
		.need_walk_end   (need_walk_end),
		.need_green_end  (need_green_end),
		.need_yellow_end (need_yellow_end),
		.ew_straight     (ew_straight),
		.sn_straight     (sn_straight),
		.es_turn         (es_turn),
		.wn_turn         (wn_turn),
		.sw_turn         (sw_turn),
		.ne_turn         (ne_turn),
		.ews_walk        (ews_walk),
		.ewn_walk        (ewn_walk),
		.sne_walk        (sne_walk),
		.snw_walk        (snw_walk)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// the line's inputs reach the DUT at the next rising edge
	task automatic drive_line(input int step);
		int         base;
		logic [7:0] pulses;
		base   = step * FIELDS;
		pulses = vec_mem[base + F_PULSE];
		start         <= vec_mem[base + F_START][0];
		daytime       <= vec_mem[base + F_DAY][0];
		heavy_traffic <= vec_mem[base + F_HEAVY][0];
		pass_key      <= vec_mem[base + F_KEY];
		walk_end      <= pulses[2];
		green_end     <= pulses[1];
		yellow_end    <= pulses[0];
	endtask

	task automatic compare_output(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (actual !== expected) begin
			$display("FAIL %s at step %0d expected %h actual %h",
				name, cur_step, expected, actual);
			$display("Checks failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic check_line(input int step);
		int         base;
		logic [7:0] need_exp;
		logic [7:0] turn_exp;
		base     = step * FIELDS;
		need_exp = vec_mem[base + F_NEED];
		turn_exp = vec_mem[base + F_TURNS];
		cur_step = step;
		compare_output("need_walk_end", {7'b0, need_exp[2]}, {7'b0, need_walk_end});
		compare_output("need_green_end", {7'b0, need_exp[1]}, {7'b0, need_green_end});
		compare_output("need_yellow_end", {7'b0, need_exp[0]}, {7'b0, need_yellow_end});
		compare_output("ew_straight", vec_mem[base + F_EW], {5'b0, ew_straight});
		compare_output("sn_straight", vec_mem[base + F_SN], {5'b0, sn_straight});
		compare_output("es_turn", {7'b0, turn_exp[3]}, {7'b0, es_turn});
		compare_output("wn_turn", {7'b0, turn_exp[2]}, {7'b0, wn_turn});
		compare_output("sw_turn", {7'b0, turn_exp[1]}, {7'b0, sw_turn});
		compare_output("ne_turn", {7'b0, turn_exp[0]}, {7'b0, ne_turn});
		compare_output("ews_walk", vec_mem[base + F_EWS], {5'b0, ews_walk});
		compare_output("ewn_walk", vec_mem[base + F_EWN], {5'b0, ewn_walk});
		compare_output("sne_walk", vec_mem[base + F_SNE], {5'b0, sne_walk});
		compare_output("snw_walk", vec_mem[base + F_SNW], {5'b0, snw_walk});
	endtask

	initial begin
		int step;
		reset         = 1'b1;
		start         = 1'b0;
		daytime       = 1'b0;
		heavy_traffic = 1'b0;
		pass_key      = '0;
		walk_end      = 1'b0;
		green_end     = 1'b0;
		yellow_end    = 1'b0;
		cur_step      = 0;
		$readmemh("verification/tb_input.txt", vec_mem);

		repeat (8) @(posedge clk);
		reset <= 1'b0;
		drive_line(0);

		// line n is sampled at the edge after it is driven and checked at the falling edge
		for (step = 0; step < NUM_LINES; step++) begin
			@(posedge clk);
			if (step + 1 < NUM_LINES) begin
				drive_line(step + 1);
			end
			@(negedge clk);
			check_line(step);
		end

		$display("All checks passed");
		$finish;
	end

	// twice the length of the stimulus leaves room for reset and the pipeline step
	initial begin
		#(TIMEOUT_NS);
		$display("the run did not finish within the watchdog time of %0d ns", TIMEOUT_NS);
		$display("Checks failed");
		$fatal(1, "watchdog expired");
	end

endmodule

/* verification/tb_input.txt */
// in: start daytime heavy_traffic pass_key pulses{walk_end,green_end,yellow_end}
// out next cycle: needs{walk,green,yellow} ew sn turns{es,wn,sw,ne} ews ewn sne snw
0 1 0 00 0   0 1 1 0 1 1 1 1
0 1 0 00 7   0 1 1 0 1 1 1 1
1 1 0 04 0   0 1 1 0 1 1 1 1
0 1 0 04 0   4 4 1 0 1 4 1 1
0 1 0 00 3   4 4 1 0 1 4 1 1
0 1 0 00 0   4 4 1 0 1 4 1 1
0 1 0 00 4   2 4 1 0 1 2 1 1
0 1 0 00 5   2 4 1 0 1 2 1 1
0 1 0 00 2   1 2 1 0 1 2 1 1
0 1 0 00 0   1 2 1 0 1 2 1 1
0 1 0 00 1   0 1 1 0 1 1 1 1
0 1 0 00 0   0 1 1 0 1 1 1 1
0 1 0 00 0   2 1 4 0 1 1 1 1
0 1 0 00 4   2 1 4 0 1 1 1 1
0 1 0 00 0   2 1 4 0 1 1 1 1
0 1 0 00 2   1 1 2 0 1 1 1 1
0 1 0 00 1   0 1 1 0 1 1 1 1
0 1 1 00 0   0 1 1 0 1 1 1 1
0 1 1 00 0   4 4 1 8 1 4 1 1
0 1 1 00 4   2 4 1 8 1 2 1 1
0 1 1 00 2   1 2 1 0 1 2 1 1
0 1 1 00 1   0 1 1 0 1 1 1 1
0 1 1 00 0   4 4 1 4 4 1 1 1
0 1 1 00 4   2 4 1 4 2 1 1 1
0 1 1 00 2   1 2 1 0 2 1 1 1
0 1 1 00 1   0 1 1 0 1 1 1 1
0 1 1 00 0   4 1 4 2 1 1 4 1
0 1 1 00 0   4 1 4 2 1 1 4 1
0 1 1 00 4   2 1 4 2 1 1 2 1
0 1 1 00 2   1 1 2 0 1 1 2 1
0 1 1 00 1   0 1 1 0 1 1 1 1
0 1 1 00 0   4 1 4 1 1 1 1 4
0 1 1 00 4   2 1 4 1 1 1 1 2
0 1 1 00 2   1 1 2 0 1 1 1 2
0 1 0 00 1   0 1 1 0 1 1 1 1
0 1 0 20 0   0 1 1 0 1 1 1 1
0 1 0 20 0   4 4 1 0 4 1 1 1
0 1 0 00 4   2 4 1 0 2 1 1 1
0 1 0 00 2   1 2 1 0 2 1 1 1
0 1 0 00 1   0 1 1 0 1 1 1 1
0 0 0 00 0   0 1 1 0 1 1 1 1
0 0 0 00 0   0 1 1 0 1 1 1 1
0 0 0 00 7   0 1 1 0 1 1 1 1
0 0 0 00 0   0 1 1 0 1 1 1 1
0 1 0 00 0   0 1 1 0 1 1 1 1
0 1 0 08 0   4 1 4 0 1 1 4 1
0 1 0 00 4   2 1 4 0 1 1 2 1
0 1 0 00 2   1 1 2 0 1 1 2 1
0 1 0 00 1   0 1 1 0 1 1 1 1
0 1 0 00 0   0 1 1 0 1 1 1 1
0 1 0 86 0   4 4 1 0 1 4 1 1
0 1 0 00 4   2 4 1 0 1 2 1 1
0 1 0 00 2   1 2 1 0 1 2 1 1
0 1 0 00 1   0 1 1 0 1 1 1 1
0 1 0 00 0   0 1 1 0 1 1 1 1
0 1 0 60 0   2 1 4 0 1 1 1 1
0 1 0 00 2   1 1 2 0 1 1 1 1
0 1 0 00 1   0 1 1 0 1 1 1 1

/* verilog.f */
src/tl_pkg.sv
src/phase_sequencer.sv
src/walk_grant.sv
src/signal_head_decoder.sv
src/traffic_light_ctrl.sv
verification/tb_traffic_light_ctrl.sv

/* Makefile */
# Verilator build and run of the signal-light controller testbench

TOP = tb_traffic_light_ctrl

.PHONY: all lint clean

all:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f verilog.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir
